/* include/uart_params.svh */
// ####################################################################
// Serial link parameters shared by the echo design
// ####################################################################
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// Bit timing
`define UART_CLKS_PER_BIT 16 // Set to 104 for 12 MHz at 115200 baud

// Frame shape
`define UART_DATA_BITS 8 // Data bits, sent LSB first
`define UART_FRAME_BITS 11 // Start + data + parity + stop

// Parity sense
// 0 gives even parity, 1 gives odd parity
`define UART_PARITY_ODD 0

// Status counters
`define LINK_COUNT_BITS 16 // Each counter saturates at all ones

`endif

/* logic/uart_pkg.sv */
// ####################################################################
// Serial frame types for the UART receiver and transmitter
// ####################################################################
`include "uart_params.svh"

`default_nettype none

package uart_pkg;

    // Field view of one frame word
    // Start bit sits in the LSB since it is the first bit on the line
    typedef struct packed {
        logic                       stop;   // High for a valid frame
        logic                       parity; // Even or odd per UART_PARITY_ODD
        logic [`UART_DATA_BITS-1:0] data;   // Payload byte
        logic                       start;  // Low for a valid frame
    } frame_fields_t;

    // One frame word seen two ways
    // raw is used while bits shift in or out
    // fields is used when the frame is built or judged
    typedef union packed {
        logic [`UART_FRAME_BITS-1:0] raw;
        frame_fields_t               fields;
    } frame_word_u;

    // Position inside a serial frame
    typedef enum logic [2:0] {
        PHASE_IDLE,   // Line high, waiting for a start edge
        PHASE_START,  // Start bit
        PHASE_DATA,   // Data bits
        PHASE_PARITY, // Parity bit
        PHASE_STOP    // Stop bit
    } bit_phase_e;

endpackage

`default_nettype wire

/* logic/link_pkg.sv */
// ####################################################################
// Status types for the echo link
// ####################################################################
`include "uart_params.svh"

`default_nettype none

package link_pkg;

    // Outcome for one received byte
    typedef enum logic [1:0] {
        VERDICT_GOOD,    // Echoed back
        VERDICT_PARITY,  // Dropped, parity mismatch
        VERDICT_FRAMING  // Dropped, stop bit low
    } byte_verdict_e;

    // Running totals per verdict
    typedef struct packed {
        logic [`LINK_COUNT_BITS-1:0] good;
        logic [`LINK_COUNT_BITS-1:0] parity;
        logic [`LINK_COUNT_BITS-1:0] framing;
    } link_stats_t;

endpackage

`default_nettype wire

/* logic/rx_byte_if.sv */
// ####################################################################
// Received byte path from UART receiver to echo stage
// ####################################################################
`include "uart_params.svh"

`default_nettype none

interface rx_byte_if;

    logic [`UART_DATA_BITS-1:0] data;          // Received byte
    logic                       strobe;        // One cycle per new byte
    logic                       parity_error;  // Valid with strobe
    logic                       framing_error; // Valid with strobe

    // Receiver side
    modport source (output data, output strobe, output parity_error, output framing_error);

    // Echo stage side, no back-pressure
    modport sink (input data, input strobe, input parity_error, input framing_error);

endinterface

`default_nettype wire

/* logic/uart_rx.sv */
// ####################################################################
// UART receiver, oversampled with mid-bit sampling
// Checks parity and stop bit and strobes each byte with its flags
// ####################################################################
`include "uart_params.svh"

`default_nettype none

module uart_rx (
    input  logic      clk,
    input  logic      reset,
    input  logic      rx,
    rx_byte_if.source byte_out
);

    localparam int CPB   = `UART_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CPB);
    localparam int IDX_W = $clog2(`UART_DATA_BITS);

    logic                  rx_meta;  // First synchronizer flop
    logic                  rx_sync;  // Safe to use
    logic                  rx_prev;  // For edge detect
    uart_pkg::bit_phase_e  phase;
    logic [CNT_W-1:0]      clk_cnt;  // Clocks into the current bit
    logic [IDX_W-1:0]      bit_idx;  // Data bit number
    uart_pkg::frame_word_u frame_q;  // Samples so far
    uart_pkg::frame_word_u frame_next;
    logic                  mid_start;
    logic                  bit_tick;
    logic                  sample_en;
    logic                  stop_tick;

    assign mid_start = (clk_cnt == CNT_W'(CPB / 2 - 1)); // Half a bit after the edge
    assign bit_tick  = (clk_cnt == CNT_W'(CPB - 1));     // One bit after the last sample
    assign stop_tick = (phase == uart_pkg::PHASE_STOP) && bit_tick;

    // Take a sample at every bit middle, start bit included
    assign sample_en = ((phase == uart_pkg::PHASE_START) && mid_start)
                     || ((phase == uart_pkg::PHASE_DATA) && bit_tick)
                     || ((phase == uart_pkg::PHASE_PARITY) && bit_tick)
                     || stop_tick;

    // New sample enters at the MSB, so the start bit ends up in bit 0
    always_comb begin
        frame_next.raw = {rx_sync, frame_q.raw[`UART_FRAME_BITS-1:1]};
    end

    // Two-flop synchronizer, idles high like the line
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // Frame FSM
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase           <= uart_pkg::PHASE_IDLE;
            clk_cnt         <= '0;
            bit_idx         <= '0;
            byte_out.strobe <= 1'b0;
        end else begin
            byte_out.strobe <= 1'b0; // Pulse only
            clk_cnt         <= clk_cnt + 1'b1;
            case (phase)
                uart_pkg::PHASE_IDLE: begin
                    clk_cnt <= '0;
                    if (rx_prev && !rx_sync) begin // Falling edge
                        phase <= uart_pkg::PHASE_START;
                    end
                end
                uart_pkg::PHASE_START: begin
                    if (mid_start) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        // High at the middle means a glitch
                        phase   <= rx_sync ? uart_pkg::PHASE_IDLE : uart_pkg::PHASE_DATA;
                    end
                end
                uart_pkg::PHASE_DATA: begin
                    if (bit_tick) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == IDX_W'(`UART_DATA_BITS - 1)) begin
                            phase <= uart_pkg::PHASE_PARITY;
                        end
                    end
                end
                uart_pkg::PHASE_PARITY: begin
                    if (bit_tick) begin
                        clk_cnt <= '0;
                        phase   <= uart_pkg::PHASE_STOP;
                    end
                end
                uart_pkg::PHASE_STOP: begin
                    if (bit_tick) begin
                        clk_cnt         <= '0;
                        phase           <= uart_pkg::PHASE_IDLE;
                        byte_out.strobe <= 1'b1; // Byte and flags land together
                    end
                end
                default: phase <= uart_pkg::PHASE_IDLE;
            endcase
        end
    end

    // Shift register and judged byte
    always_ff @(posedge clk) begin
        if (sample_en) begin
            frame_q <= frame_next;
        end
        if (stop_tick) begin
            byte_out.data          <= frame_next.fields.data;
            // XOR over data and parity is 0 for even, 1 for odd
            byte_out.parity_error  <= (^{frame_next.fields.data, frame_next.fields.parity})
                                      ^ 1'(`UART_PARITY_ODD);
            byte_out.framing_error <= ~frame_next.fields.stop; // Stop must be high
        end
    end

endmodule

`default_nettype wire

/* logic/echo_ctrl.sv */
// ####################################################################
// Echo stage: judges bytes, counts verdicts, returns good bytes
// ####################################################################
`include "uart_params.svh"

`default_nettype none

module echo_ctrl (
    input  logic                       clk,
    input  logic                       reset,
    rx_byte_if.sink                    byte_in,
    output logic [`UART_DATA_BITS-1:0] tx_data,
    output logic                       tx_start,
    input  logic                       tx_busy,
    output link_pkg::link_stats_t      stats
);

    link_pkg::byte_verdict_e    verdict;
    logic                       echo_now;  // Good byte this cycle
    logic                       tx_free;   // Transmitter can take a byte
    logic                       pending;   // Hold register is full
    logic                       send_hold; // Hold register goes out now
    logic                       load_hold; // New byte must wait
    logic [`UART_DATA_BITS-1:0] hold_data;

    // Counter step that stops at all ones
    function automatic logic [`LINK_COUNT_BITS-1:0] sat_inc(
        input logic [`LINK_COUNT_BITS-1:0] value
    );
        return (&value) ? value : value + 1'b1;
    endfunction

    // Framing error wins over parity error
    always_comb begin
        if (byte_in.framing_error) begin
            verdict = link_pkg::VERDICT_FRAMING;
        end else if (byte_in.parity_error) begin
            verdict = link_pkg::VERDICT_PARITY;
        end else begin
            verdict = link_pkg::VERDICT_GOOD;
        end
    end

    assign echo_now  = byte_in.strobe && (verdict == link_pkg::VERDICT_GOOD);
    assign tx_free   = !tx_busy && !tx_start; // Busy rises one cycle after start
    assign send_hold = tx_free && pending;
    assign load_hold = echo_now && !(tx_free && !pending);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tx_start <= 1'b0;
            pending  <= 1'b0;
            stats    <= '0;
        end else begin
            tx_start <= send_hold || (echo_now && tx_free);
            if (send_hold) begin
                pending <= load_hold; // Refilled if a byte came in the same cycle
            end else if (load_hold) begin
                pending <= 1'b1;
            end
            if (byte_in.strobe) begin
                case (verdict)
                    link_pkg::VERDICT_GOOD:    stats.good    <= sat_inc(stats.good);
                    link_pkg::VERDICT_PARITY:  stats.parity  <= sat_inc(stats.parity);
                    link_pkg::VERDICT_FRAMING: stats.framing <= sat_inc(stats.framing);
                    default: ;
                endcase
            end
        end
    end

    // Payload path
    always_ff @(posedge clk) begin
        if (send_hold) begin
            tx_data <= hold_data;
        end else if (echo_now && tx_free) begin
            tx_data <= byte_in.data; // Straight through when idle
        end
        if (load_hold) begin
            hold_data <= byte_in.data;
        end
    end

endmodule

`default_nettype wire

/* logic/uart_tx.sv */
// ####################################################################
// UART transmitter, start + data + parity + stop, LSB first
// ####################################################################
`include "uart_params.svh"

`default_nettype none

module uart_tx (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`UART_DATA_BITS-1:0] tx_data,
    input  logic                       tx_start,
    output logic                       tx,
    output logic                       tx_busy
);

    localparam int CPB   = `UART_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CPB);
    localparam int BIT_W = $clog2(`UART_FRAME_BITS);

    uart_pkg::frame_word_u frame_load; // Frame built from tx_data
    uart_pkg::frame_word_u shift_q;    // Bit 0 is on the line
    logic [CNT_W-1:0]      clk_cnt;
    logic [BIT_W-1:0]      bit_cnt;    // Frame bit on the line
    logic                  bit_end;
    logic                  launch;

    assign bit_end = (clk_cnt == CNT_W'(CPB - 1));
    assign launch  = tx_start && !tx_busy; // Start ignored mid-frame

    always_comb begin
        frame_load.fields.start  = 1'b0;
        frame_load.fields.data   = tx_data;
        frame_load.fields.parity = (^tx_data) ^ 1'(`UART_PARITY_ODD);
        frame_load.fields.stop   = 1'b1;
    end

    // Line and bit timing
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tx      <= 1'b1; // Idle high
            tx_busy <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx      <= frame_load.fields.start;
                tx_busy <= 1'b1;
                clk_cnt <= '0;
                bit_cnt <= '0;
            end
        end else if (bit_end) begin
            clk_cnt <= '0;
            if (bit_cnt == BIT_W'(`UART_FRAME_BITS - 1)) begin
                tx      <= 1'b1; // Stop bit done, back to idle
                tx_busy <= 1'b0;
            end else begin
                tx      <= shift_q.raw[1]; // Next bit
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // Frame shift register
    always_ff @(posedge clk) begin
        if (launch) begin
            shift_q <= frame_load;
        end else if (tx_busy && bit_end) begin
            shift_q.raw <= {1'b1, shift_q.raw[`UART_FRAME_BITS-1:1]};
        end
    end

endmodule

`default_nettype wire

/* logic/uart_echo_top.sv */
// ####################################################################
// UART echo link top: receiver, echo stage, transmitter
// ####################################################################
`include "uart_params.svh"

`default_nettype none

module uart_echo_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        rx,
    output logic                        tx,
    output logic                        tx_busy,
    output logic [`LINK_COUNT_BITS-1:0] good_count,
    output logic [`LINK_COUNT_BITS-1:0] parity_count,
    output logic [`LINK_COUNT_BITS-1:0] framing_count
);

    rx_byte_if                  byte_link ();
    logic [`UART_DATA_BITS-1:0] tx_data;
    logic                       tx_start;
    link_pkg::link_stats_t      stats;

    uart_rx u_rx (
        .clk      (clk),
        .reset    (reset),
        .rx       (rx),
        .byte_out (byte_link.source)
    );

    echo_ctrl u_echo (
        .clk      (clk),
        .reset    (reset),
        .byte_in  (byte_link.sink),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .stats    (stats)
    );

    uart_tx u_tx (
        .clk      (clk),
        .reset    (reset),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

    // Status record out on plain ports
    assign good_count    = stats.good;
    assign parity_count  = stats.parity;
    assign framing_count = stats.framing;

endmodule

`default_nettype wire

/* tests/tb_uart_echo.sv */
// ####################################################################
// Testbench for the UART echo link with serial driver, tx monitor,
// reference model, compare process and watchdog
// ####################################################################
`include "uart_params.svh"

`default_nettype none

module tb_uart_echo;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CPB          = `UART_CLKS_PER_BIT;
    localparam int DW           = `UART_DATA_BITS;
    localparam int FRAME_CYCLES = `UART_FRAME_BITS * CPB;
    localparam int PERIOD       = 8;
    localparam int N_GOOD       = 12;
    localparam int N_PARITY     = 3;
    localparam int N_FRAMING    = 4;
    localparam int N_BURST      = 6;
    localparam int N_FRAMES     = N_GOOD + N_PARITY + N_FRAMING + N_BURST;
    // Each frame and its echo plus gaps and final idle time
    localparam int LIMIT_CYCLES = N_FRAMES * 2 * FRAME_CYCLES + N_FRAMES * 32 + 10 * FRAME_CYCLES;

    typedef struct packed {
        logic                    parity;  // Parity bit the DUT should send back
        link_pkg::byte_verdict_e verdict;
        logic                    echoed;
    } outcome_t;

    typedef struct packed {
        logic [DW-1:0] data;
        logic          parity;
        logic [63:0]   deadline; // Latest start-bit edge or zero when unchecked
    } expect_t;

    typedef struct packed {
        logic [63:0]   start_time;
        logic          start;
        logic [DW-1:0] data;
        logic          parity;
        logic          stop;
    } got_t;

    logic                        clk;
    logic                        reset;
    logic                        rx;
    logic                        tx;
    logic                        tx_busy;
    logic [`LINK_COUNT_BITS-1:0] good_count;
    logic [`LINK_COUNT_BITS-1:0] parity_count;
    logic [`LINK_COUNT_BITS-1:0] framing_count;
    logic [31:0]                 lfsr_state;
    expect_t                     exp_q[$];   // Echoes still owed by the DUT
    got_t                        got_q[$];   // Frames decoded on tx
    int                          exp_good;
    int                          exp_parity;
    int                          exp_framing;
    event                        frame_seen;

    uart_echo_top uut (
        .clk           (clk),
        .reset         (reset),
        .rx            (rx),
        .tx            (tx),
        .tx_busy       (tx_busy),
        .good_count    (good_count),
        .parity_count  (parity_count),
        .framing_count (framing_count)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Expected outcome of one input frame
    function automatic outcome_t expected_outcome(input logic [DW-1:0] data,
                                                  input logic bad_parity,
                                                  input logic low_stop);
        outcome_t o;
        logic     ones;
        ones = 1'b0;
        for (int i = 0; i < DW; i++) ones = ones ^ data[i]; // Odd count of ones
        o.parity = ones ^ 1'(`UART_PARITY_ODD);
        if (low_stop) o.verdict = link_pkg::VERDICT_FRAMING; // Framing wins
        else if (bad_parity) o.verdict = link_pkg::VERDICT_PARITY;
        else o.verdict = link_pkg::VERDICT_GOOD;
        o.echoed = (o.verdict == link_pkg::VERDICT_GOOD);
        return o;
    endfunction

    // Right-shifting Galois LFSR
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state); // One step per bit
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic stop_run();
        $display("sim failed");
        $fatal(1, "Testbench stopped on error");
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        stop_run();
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_counters();
        check("good_count", 32'(exp_good), 32'(good_count));
        check("parity_count", 32'(exp_parity), 32'(parity_count));
        check("framing_count", 32'(exp_framing), 32'(framing_count));
    endtask

    task automatic drive_bit(input logic value);
        rx = value;
        repeat (CPB) @(negedge clk); // Ends on the next bit boundary
    endtask

    // Sends one frame starting at the current falling edge
    task automatic send_frame(input logic [DW-1:0] data, input logic bad_parity,
                              input logic low_stop);
        outcome_t o;
        expect_t  e;
        o = expected_outcome(data, bad_parity, low_stop);
        if (o.echoed) begin
            e.data   = data;
            e.parity = o.parity;
            // Stop middle on the line plus two synchronizer cycles and three of echo path
            e.deadline = (!tx_busy && exp_q.size() == 0)
                       ? 64'($time) + 64'((FRAME_CYCLES - CPB / 2 + 5) * PERIOD) : '0;
            exp_q.push_back(e);
        end
        case (o.verdict)
            link_pkg::VERDICT_GOOD:   exp_good++;
            link_pkg::VERDICT_PARITY: exp_parity++;
            default:                  exp_framing++;
        endcase
        drive_bit(1'b0);
        for (int i = 0; i < DW; i++) drive_bit(data[i]); // LSB first
        drive_bit(o.parity ^ bad_parity);
        drive_bit(!low_stop);
        if (low_stop) drive_bit(1'b1); // Line back to idle
        check_counters(); // Counters moved before the stop bit ended
    endtask

    // Waits for all owed echoes and an idle transmitter
    task automatic wait_drained();
        int n;
        n = 0;
        while ((exp_q.size() != 0 || tx_busy) && n < 3 * FRAME_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0)
            report_failure($sformatf("Missing echo: %0d byte(s) never came back on tx",
                                     exp_q.size()));
    endtask

    // Decodes frames on tx at bit middles
    initial begin : monitor
        got_t g;
        wait (reset === 1'b0);
        forever begin
            @(negedge tx);
            g.start_time = 64'($time);
            repeat (CPB / 2) @(negedge clk);
            g.start = tx;
            for (int i = 0; i < DW; i++) begin
                repeat (CPB) @(negedge clk);
                g.data[i] = tx;
            end
            repeat (CPB) @(negedge clk);
            g.parity = tx;
            repeat (CPB) @(negedge clk);
            g.stop = tx;
            check("tx_busy during frame", 32'd1, 32'(tx_busy));
            got_q.push_back(g);
            -> frame_seen;
        end
    end

    initial begin : compare
        got_t    g;
        expect_t e;
        forever begin
            @(frame_seen);
            while (got_q.size() != 0) begin
                g = got_q.pop_front();
                if (exp_q.size() == 0)
                    report_failure($sformatf("Unexpected frame %02h on tx", g.data));
                e = exp_q.pop_front();
                check("echo start bit", 32'd0, 32'(g.start));
                check("echo data", 32'(e.data), 32'(g.data));
                check("echo parity", 32'(e.parity), 32'(g.parity));
                check("echo stop bit", 32'd1, 32'(g.stop));
                if (e.deadline != '0 && g.start_time > e.deadline)
                    report_failure($sformatf("Echo of %02h started at %0d ns, after %0d ns",
                                             e.data, g.start_time, e.deadline));
            end
        end
    end

    initial begin : watchdog
        #(LIMIT_CYCLES * PERIOD);
        $display("Timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
        stop_run();
    end

    initial begin : main
        logic [31:0] r;
        rx          = 1'b1;
        reset       = 1'b1;
        lfsr_state  = 32'd83539;
        exp_good    = 0;
        exp_parity  = 0;
        exp_framing = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check("tx after reset", 32'd1, 32'(tx));
        check("tx_busy after reset", 32'd0, 32'(tx_busy));
        check_counters();
        for (int i = 0; i < N_GOOD; i++) begin // Good bytes with idle gaps
            random_bits(DW, r);
            send_frame(r[DW-1:0], 1'b0, 1'b0);
            wait_drained();
            random_bits(4, r);
            repeat (int'(r[3:0]) + 1) @(negedge clk);
        end
        for (int i = 0; i < N_PARITY; i++) begin // Bad parity frames are dropped
            random_bits(DW, r);
            send_frame(r[DW-1:0], 1'b1, 1'b0);
        end
        wait_drained();
        for (int i = 0; i < N_FRAMING; i++) begin // Low stop and every other one bad parity
            random_bits(DW, r);
            send_frame(r[DW-1:0], 1'(i % 2), 1'b1);
        end
        wait_drained();
        for (int i = 0; i < N_BURST; i++) begin // Back to back frames fill the hold register
            random_bits(DW, r);
            send_frame(r[DW-1:0], 1'b0, 1'b0);
        end
        wait_drained();
        repeat (FRAME_CYCLES) @(negedge clk); // Room for any stray echo
        check("tx idle at end", 32'd1, 32'(tx));
        check_counters();
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+include
logic/uart_pkg.sv
logic/link_pkg.sv
logic/rx_byte_if.sv
logic/uart_rx.sv
logic/echo_ctrl.sv
logic/uart_tx.sv
logic/uart_echo_top.sv
tests/tb_uart_echo.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the UART echo testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
{ verilator --binary --timing --top-module tb_uart_echo -Mdir obj_dir -f build.f &&
    ./obj_dir/Vtb_uart_echo; } > sim.log 2>&1 ||
    echo "sim failed: build or run returned an error" >> sim.log
grep -q "sim failed" sim.log && { echo "FAILED, see sim.log"; exit 1; } || echo "PASSED"
exit 0
